// ==== include/wbs_macros.svh ====
// address map, RAM size and millisecond divider macros for the board bus slaves
`ifndef WBS_MACROS_SVH
`define WBS_MACROS_SVH

// RAM slave geometry
// word address width, 8K words of 16 bits
`define WBS_RAM_AW        13

// RAM sits in the low 16K bytes
// bits 15:14 of the byte address must match this value
`define WBS_RAM_TOP_BITS  2'b00

// board register window
`define WBS_REG_BASE      16'o177700   // octal base as seen by the CPU
`define WBS_REG_SPAN_AW   4            // 16 byte window, low 4 address bits free

// display scan prescaler
// wb_clk cycles per millisecond tick at 50 MHz
`define WBS_MS_DIV        50000

// width of the button port on the board
`define WBS_BTN_W         4

// seven segment digit count on the board
`define WBS_DIGITS        6

// last digit index, the scan wraps here from digit 0
`define WBS_DIGIT_LAST    3'd5

`endif

// ==== design/wbs_pkg.sv ====
// bus vector typedefs and RAM acknowledge state enum
package wbs_pkg;

   // byte address from the master, 17 bits
   typedef logic [16:0] wb_adr_t;

   // bus data word
   typedef logic [15:0] wb_dat_t;

   // byte lane select, bit 0 is the low byte
   typedef logic [1:0] wb_sel_t;

   // scanned display digit index 0..5
   typedef logic [2:0] digit_t;

   // seven segment pattern, active low, bit 7 is the dot
   typedef logic [7:0] seg_t;

   // RAM read acknowledge sequencer
   // IDLE no read pending
   // WAIT registered read port is fetching
   // DONE read data valid, ack high
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      WAIT = 2'd1,
      DONE = 2'd2
   } ram_ack_state_t;

endpackage

// ==== design/wbs_decode.sv ====
// address decoder with per-slave strobes, acknowledge OR and read data mux
`timescale 1ns/1ps
`include "wbs_macros.svh"

module wbs_decode
   import wbs_pkg::*;
(
   input  logic    cyc_i,          // master cycle
   input  logic    stb_i,          // master strobe
   input  wb_adr_t adr_i,          // master byte address
   input  logic    ram_ack_i,      // RAM slave ack
   input  logic    reg_ack_i,      // board register ack
   input  wb_dat_t ram_dat_i,      // RAM read data
   input  wb_dat_t reg_dat_i,      // board register read data
   output logic    ram_stb_o,      // strobe to RAM slave
   output logic    reg_stb_o,      // strobe to board registers
   output logic    ack_o,          // ack back to master
   output wb_dat_t dat_o           // read data back to master
);

   localparam wb_dat_t REG_BASE = `WBS_REG_BASE;

   logic    bus_req;               // active bus phase
   logic    ram_hit;
   logic    reg_hit;
   wb_dat_t ram_lane;
   wb_dat_t reg_lane;

   assign bus_req = cyc_i & stb_i;

   // window compare, bit 16 is not decoded
   assign ram_hit = (adr_i[15:14] == `WBS_RAM_TOP_BITS);
   assign reg_hit = (adr_i[15:`WBS_REG_SPAN_AW] == REG_BASE[15:`WBS_REG_SPAN_AW]);

   assign ram_stb_o = bus_req & ram_hit;
   assign reg_stb_o = bus_req & reg_hit;

   // unmapped address gets no strobe and never an ack
   assign ack_o = ram_ack_i | reg_ack_i;

   // AND-OR mux, zero when nothing strobed
   assign ram_lane = ram_stb_o ? ram_dat_i : '0;
   assign reg_lane = reg_stb_o ? reg_dat_i : '0;
   assign dat_o    = ram_lane | reg_lane;

endmodule

// ==== design/wbs_ram.sv ====
// 8K x 16 RAM slave with byte lane writes and two cycle read acknowledge
`timescale 1ns/1ps
`include "wbs_macros.svh"

module wbs_ram
   import wbs_pkg::*;
(
   input  logic    wb_clk,
   input  logic    rst_i,
   input  logic    cyc_i,
   input  logic    stb_i,          // decoded RAM strobe
   input  logic    we_i,
   input  wb_adr_t adr_i,
   input  wb_sel_t sel_i,
   input  wb_dat_t dat_i,
   output wb_dat_t dat_o,
   output logic    ack_o
);

   localparam int RAM_WORDS = 1 << `WBS_RAM_AW;

   wb_dat_t                  mem [RAM_WORDS];
   wb_dat_t                  rd_q;         // registered read port
   logic [`WBS_RAM_AW-1:0]   word_adr;
   logic                     wr_en;
   logic                     rd_req;
   ram_ack_state_t           state_q;

   assign word_adr = adr_i[`WBS_RAM_AW:1];  // byte address to word index
   assign wr_en    = cyc_i & stb_i & we_i;
   assign rd_req   = cyc_i & stb_i & ~we_i;

   // byte lane write, read port always follows the address
   always_ff @(posedge wb_clk)
   begin
      if (wr_en & sel_i[0])
         mem[word_adr][7:0] <= dat_i[7:0];
      if (wr_en & sel_i[1])
         mem[word_adr][15:8] <= dat_i[15:8];
      rd_q <= mem[word_adr];
   end

   // read ack sequencer, IDLE -> WAIT -> DONE while strobe held
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         state_q <= IDLE;
      else if (!rd_req)
         state_q <= IDLE;                    // strobe or cycle dropped
      else
      begin
         case (state_q)
            IDLE:    state_q <= WAIT;
            WAIT:    state_q <= DONE;
            default: state_q <= DONE;        // hold until master drops stb
         endcase
      end
   end

   // writes ack at once, reads once the port has settled
   assign ack_o = cyc_i & stb_i & (we_i | (state_q == DONE));
   assign dat_o = rd_q;

endmodule

// ==== design/wbs_board_regs.sv ====
// display word registers, button readback and timer enable latch
`timescale 1ns/1ps
`include "wbs_macros.svh"

module wbs_board_regs
   import wbs_pkg::*;
(
   input  logic                  wb_clk,
   input  logic                  rst_i,
   input  logic                  stb_i,       // decoded register strobe
   input  logic                  we_i,
   input  wb_adr_t               adr_i,
   input  wb_dat_t               dat_i,
   input  logic [`WBS_BTN_W-1:0] button_i,    // push buttons, active low
   output wb_dat_t               dat_o,
   output logic                  ack_o,
   output wb_dat_t               disp0_o,     // digits 0 and 1
   output wb_dat_t               disp1_o,     // digits 2 and 3
   output logic                  timer_en_o
);

   logic    wr_en;
   wb_dat_t disp0_q;
   wb_dat_t disp1_q;
   logic    tena_q;

   assign wr_en = stb_i & we_i;

   // adr bit 1 picks the word, whole word written
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         disp0_q <= '0;
         disp1_q <= '0;
      end
      else if (wr_en)
      begin
         if (adr_i[1])
            disp1_q <= dat_i;
         else
            disp0_q <= dat_i;
      end
   end

   // button 0 sets, button 1 clears, clear has priority
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         tena_q <= 1'b0;
      else if (!button_i[1])
         tena_q <= 1'b0;
      else if (!button_i[0])
         tena_q <= 1'b1;
   end

   // raw button levels, upper bits zero
   assign dat_o      = {{($bits(wb_dat_t)-`WBS_BTN_W){1'b0}}, button_i};
   assign ack_o      = stb_i;                 // zero wait state
   assign disp0_o    = disp0_q;
   assign disp1_o    = disp1_q;
   assign timer_en_o = tena_q;

endmodule

// ==== design/wbs_led_scan.sv ====
// millisecond prescaler, six digit scan counter and segment/digit drive
`timescale 1ns/1ps
`include "wbs_macros.svh"

module wbs_led_scan
   import wbs_pkg::*;
(
   input  logic                   wb_clk,
   input  logic                   rst_i,
   input  wb_dat_t                disp0_i,
   input  wb_dat_t                disp1_i,
   output seg_t                   hex_o,      // segments, active low
   output logic [`WBS_DIGITS-1:0] hsel_o      // digit select, active low
);

   localparam int unsigned MS_DIV = `WBS_MS_DIV;
   localparam int          PRE_W  = (MS_DIV > 1) ? $clog2(MS_DIV) : 1;
   localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(MS_DIV - 1);

   logic [PRE_W-1:0] pre_cnt;
   logic             ms_tick;    // one cycle per millisecond
   digit_t           digit_q;

   // prescaler, wraps at MS_DIV-1
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         pre_cnt <= '0;
         ms_tick <= 1'b0;
      end
      else
      begin
         ms_tick <= (pre_cnt == PRE_LAST);
         pre_cnt <= (pre_cnt == PRE_LAST) ? '0 : pre_cnt + 1'b1;
      end
   end

   // scan walks down, 0 wraps to 5
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         digit_q <= '0;
      else if (ms_tick)
         digit_q <= (digit_q == '0) ? `WBS_DIGIT_LAST : digit_q - 1'b1;
   end

   always_comb
   begin
      case (digit_q)
         3'd0:    hex_o = ~disp0_i[7:0];
         3'd1:    hex_o = ~disp0_i[15:8];
         3'd2:    hex_o = ~disp1_i[7:0];
         3'd3:    hex_o = ~disp1_i[15:8];
         default: hex_o = '1;                 // digits 4, 5 blank
      endcase
   end

   assign hsel_o = ~(`WBS_DIGITS'(1) << digit_q);  // one low bit

endmodule

// ==== design/wbs_board_top.sv ====
// board top with bus decoder, RAM slave, board registers and display scanner
`timescale 1ns/1ps

module wbs_board_top
   import wbs_pkg::*;
(
   input  logic       wb_clk,
   input  logic       rst_i,
   input  logic       cyc_i,
   input  logic       stb_i,
   input  logic       we_i,
   input  wb_adr_t    adr_i,
   input  wb_sel_t    sel_i,
   input  wb_dat_t    dat_i,
   output wb_dat_t    dat_o,
   output logic       ack_o,
   input  logic [3:0] button_i,       // active low
   output seg_t       hex_o,
   output logic [5:0] hsel_o,
   output logic       timer_en_o
);

   logic    ram_stb, reg_stb;         // decoded strobes
   logic    ram_ack, reg_ack;
   wb_dat_t ram_dat, reg_dat;
   wb_dat_t disp0, disp1;             // display words to scanner

   wbs_decode u_wbs_decode (
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .adr_i     (adr_i),
      .ram_ack_i (ram_ack),
      .reg_ack_i (reg_ack),
      .ram_dat_i (ram_dat),
      .reg_dat_i (reg_dat),
      .ram_stb_o (ram_stb),
      .reg_stb_o (reg_stb),
      .ack_o     (ack_o),
      .dat_o     (dat_o)
   );

   wbs_ram u_wbs_ram (
      .wb_clk (wb_clk),
      .rst_i  (rst_i),
      .cyc_i  (cyc_i),
      .stb_i  (ram_stb),
      .we_i   (we_i),
      .adr_i  (adr_i),
      .sel_i  (sel_i),
      .dat_i  (dat_i),
      .dat_o  (ram_dat),
      .ack_o  (ram_ack)
   );

   wbs_board_regs u_wbs_board_regs (
      .wb_clk (wb_clk), .rst_i (rst_i), .stb_i (reg_stb), .we_i (we_i),
      .adr_i (adr_i), .dat_i (dat_i), .button_i (button_i),
      .dat_o (reg_dat), .ack_o (reg_ack),
      .disp0_o (disp0), .disp1_o (disp1), .timer_en_o (timer_en_o)
   );

   wbs_led_scan u_wbs_led_scan (
      .wb_clk (wb_clk), .rst_i (rst_i), .disp0_i (disp0), .disp1_i (disp1),
      .hex_o (hex_o), .hsel_o (hsel_o)
   );

endmodule

// ==== dv/wbs_board_chk.sv ====
// bound concurrent assertions on acknowledge timing, reset state and digit select
`timescale 1ns/1ps

module wbs_board_chk
(
   input logic       wb_clk,
   input logic       rst_i,
   input logic       we_i,
   input logic       ram_stb_i,     // decoded RAM strobe inside the top
   input logic       reg_stb_i,     // decoded register strobe
   input logic       ack_i,         // ack seen by the master
   input logic [5:0] hsel_i
);

   logic        ram_rd;
   logic        zero_wait;
   int unsigned fail_cnt = 0;       // failed assertion count

   assign ram_rd    = ram_stb_i & ~we_i;
   assign zero_wait = (ram_stb_i & we_i) | reg_stb_i;

   // RAM read acks two edges after the strobe is first seen
   a_ram_rd_lat : assert property (@(posedge wb_clk) disable iff (rst_i)
      $rose(ram_rd) |-> !ack_i ##1 !ack_i ##1 ack_i)
      else
      begin
         fail_cnt++;
         $error("RAM read ack not two edges after strobe");
      end

   // writes and register accesses ack in the strobe cycle
   a_zero_wait : assert property (@(posedge wb_clk) disable iff (rst_i)
      zero_wait |-> ack_i)
      else
      begin
         fail_cnt++;
         $error("write or register access not acked in strobe cycle");
      end

   a_rst_ack : assert property (@(posedge wb_clk) rst_i |-> !ack_i)
      else
      begin
         fail_cnt++;
         $error("ack high during reset");
      end

   // exactly one digit driven
   a_hsel_one : assert property (@(posedge wb_clk) disable iff (rst_i) $onehot(~hsel_i))
      else
      begin
         fail_cnt++;
         $error("digit select not one-hot low");
      end

endmodule

// ==== dv/wbs_board_tb.sv ====
// testbench with clock, reset, bus master tasks, xorshift stimulus and scoreboard
`timescale 1ns/1ps
`include "wbs_macros.svh"

module wbs_board_tb;
   import wbs_pkg::*;

   localparam int ACK_TMO  = 20;                       // cycles per bus access
   localparam int SCAN_TMO = 7 * `WBS_MS_DIV + 100;

   logic       wb_clk;
   logic       rst_i;
   logic       cyc_i, stb_i, we_i;
   wb_adr_t    adr_i;
   wb_sel_t    sel_i;
   wb_dat_t    dat_i;
   wb_dat_t    dat_o;
   logic       ack_o;
   logic [3:0] button_i;
   seg_t       hex_o;
   logic [5:0] hsel_o;
   logic       timer_en_o;

   logic [31:0] rng;
   wb_dat_t     ram_model [8192];         // scoreboard copy of RAM
   wb_adr_t     adr_list [20];
   wb_dat_t     exp_disp0, exp_disp1;

   wbs_board_top u_wbs_board_top (.*);

   bind wbs_board_top wbs_board_chk u_wbs_board_chk (
      .wb_clk (wb_clk), .rst_i (rst_i), .we_i (we_i), .ram_stb_i (ram_stb),
      .reg_stb_i (reg_stb), .ack_i (ack_o), .hsel_i (hsel_o)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;
   end

   // a failed bound assertion ends the run
   always @(negedge wb_clk)
   begin
      if (u_wbs_board_top.u_wbs_board_chk.fail_cnt != 0)
      begin
         $display("a bound assertion in the checker failed");
         $display("TB FAILED");
         $fatal(1, "bound assertion failed");
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // segment pattern a digit should show
   function automatic seg_t seg_for(input int dig, input wb_dat_t d0, input wb_dat_t d1);
      case (dig)
         0:       return ~d0[7:0];
         1:       return ~d0[15:8];
         2:       return ~d1[7:0];
         3:       return ~d1[15:8];
         default: return 8'hff;
      endcase
   endfunction

   task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
      assert (exp === act)
      else
      begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // one access with ack timeout and an idle cycle after
   task automatic bus_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                             input wb_dat_t wdat, output wb_dat_t rdat);
      int n;
      @(negedge wb_clk);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      sel_i = sel;
      dat_i = wdat;
      n = 0;
      #1;
      while (!ack_o)
      begin
         n++;
         if (n > ACK_TMO)
         begin
            $display("no ack from slave at address %h", adr);
            $display("TB FAILED");
            $fatal(1, "ack timeout");
         end
         @(negedge wb_clk);
         #1;
      end
      rdat = dat_o;                         // valid in ack cycle
      @(negedge wb_clk);
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   initial
   begin
      int       dig, prev_dig, n;
      logic [5:0] seen;
      wb_dat_t  rd, wd;
      wb_sel_t  sel;
      wb_adr_t  reg_base;
      rng = 32'h6f66;
      rst_i = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      sel_i = '0;
      dat_i = '0;
      button_i = 4'hf;                      // all released
      reg_base = {1'b0, 16'(`WBS_REG_BASE)};
      @(negedge wb_clk);
      // RAM read strobe held in reset must get no ack
      cyc_i = 1'b1;
      stb_i = 1'b1;
      repeat (15) @(negedge wb_clk);
      cyc_i = 1'b0;
      stb_i = 1'b0;
      rst_i = 1'b0;
      @(negedge wb_clk);

      // reset state
      check_eq("reset_timer_en", 16'd0, {15'd0, timer_en_o});
      check_eq("reset_hex", 16'h00ff, {8'd0, hex_o});
      check_eq("reset_hsel", 16'h003e, {10'd0, hsel_o});

      // full writes seed the model before random byte lanes
      for (int i = 0; i < 20; i++)
      begin
         rng = xorshift(rng);
         adr_list[i] = {1'b0, 2'b00, rng[13:1], 1'b0};
         wd = rng[31:16];
         ram_model[adr_list[i][13:1]] = wd;
         bus_access(1'b1, adr_list[i], 2'b11, wd, rd);
      end
      for (int i = 0; i < 20; i++)
      begin
         rng = xorshift(rng);
         sel = rng[1:0];
         wd  = rng[31:16];
         if (sel[0])
            ram_model[adr_list[i][13:1]][7:0] = wd[7:0];
         if (sel[1])
            ram_model[adr_list[i][13:1]][15:8] = wd[15:8];
         bus_access(1'b1, adr_list[i], sel, wd, rd);
      end
      for (int i = 0; i < 20; i++)
      begin
         bus_access(1'b0, adr_list[i], 2'b11, 16'd0, rd);
         check_eq("ram_byte_lane", ram_model[adr_list[i][13:1]], rd);
      end

      // display words then walk the scan
      rng = xorshift(rng);
      exp_disp0 = rng[15:0];
      exp_disp1 = rng[31:16];
      bus_access(1'b1, reg_base, 2'b11, exp_disp0, rd);
      bus_access(1'b1, reg_base + 17'd2, 2'b11, exp_disp1, rd);
      seen = '0;
      prev_dig = -1;
      n = 0;
      while (seen != 6'h3f)
      begin
         n++;
         if (n > SCAN_TMO)
         begin
            $display("display scan did not visit all six digits");
            $display("TB FAILED");
            $fatal(1, "scan timeout");
         end
         dig = 0;
         for (int b = 0; b < 6; b++)
            if (!hsel_o[b])
               dig = b;
         if (dig != prev_dig)
         begin
            check_eq("scan_segments", {8'd0, seg_for(dig, exp_disp0, exp_disp1)},
                     {8'd0, hex_o});
            seen[dig] = 1'b1;
            prev_dig = dig;
         end
         @(negedge wb_clk);
      end

      // button readback
      for (int i = 0; i < 8; i++)
      begin
         rng = xorshift(rng);
         button_i = rng[3:0];
         bus_access(1'b0, reg_base, 2'b11, 16'd0, rd);
         check_eq("button_read", {12'd0, rng[3:0]}, rd);
      end

      // timer enable latch checked one edge after each button change
      button_i = 4'b1110;
      @(negedge wb_clk);
      check_eq("timer_set", 16'd1, {15'd0, timer_en_o});
      button_i = 4'b1101;
      @(negedge wb_clk);
      check_eq("timer_clear", 16'd0, {15'd0, timer_en_o});
      button_i = 4'b1110;
      @(negedge wb_clk);
      check_eq("timer_set_again", 16'd1, {15'd0, timer_en_o});
      button_i = 4'b1100;
      @(negedge wb_clk);
      check_eq("timer_both_low", 16'd0, {15'd0, timer_en_o});
      button_i = 4'hf;

      @(negedge wb_clk);
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+include
design/wbs_pkg.sv
design/wbs_decode.sv
design/wbs_ram.sv
design/wbs_board_regs.sv
design/wbs_led_scan.sv
design/wbs_board_top.sv
dv/wbs_board_chk.sv
dv/wbs_board_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the board bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f \
   --top-module wbs_board_tb -o wbs_board_sim \
   && ./obj_dir/wbs_board_sim | tee /dev/stderr | grep -q "TB PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
